//--- Bender.yml
package:
  name: ex_stage

sources:
  - src/ex_isa_pkg.sv
  - src/ex_pipe_pkg.sv
  - src/ex_issue_if.sv
  - src/ex_stage_reg.sv
  - src/ex_alu.sv
  - src/ex_branch_res.sv
  - src/ex_top.sv
  - target: simulation
    files:
      - verif/ex_checker.sv
      - verif/ex_tb.sv

//--- src.f
src/ex_isa_pkg.sv
src/ex_pipe_pkg.sv
src/ex_issue_if.sv
src/ex_stage_reg.sv
src/ex_alu.sv
src/ex_branch_res.sv
src/ex_top.sv
verif/ex_checker.sv
verif/ex_tb.sv

//--- src/ex_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I integer ALU for register and
// immediate operations
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_alu (
  ex_issue_if.alu            iss,
  output ex_isa_pkg::word_t  result
);

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  word_t              op_a;
  word_t              op_b;
  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign op_a  = iss.op.port_a;
  assign op_b  = iss.op.port_b;
  // Only the low bits of port_b count as shift amount
  assign shamt = op_b[SHAMT_W-1:0];

  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    result = '0;
    case (iss.op.alu_op)
      ALU_ADD:   result = op_a + op_b;
      ALU_SUB:   result = op_a - op_b;
      ALU_AND:   result = op_a & op_b;
      ALU_OR:    result = op_a | op_b;
      ALU_XOR:   result = op_a ^ op_b;
      ALU_SLL:   result = op_a << shamt;
      ALU_SRL:   result = op_a >> shamt;
      // Sign bit fills from the left
      ALU_SRA:   result = $unsigned($signed(op_a) >>> shamt);
      ALU_SLT:   result = word_t'(lt_signed);
      ALU_SLTU:  result = word_t'(lt_unsigned);
      ALU_PASSB: result = op_b;
      default:   result = '0;
    endcase
  end

  // Decode must only send defined ALU codes with an ALU operation
  a_alu_op_defined: assert property (
    @(posedge iss.CLK) disable iff (!iss.nRST)
    (iss.valid && iss.op.kind == KIND_ALU) |->
      iss.op.alu_op inside {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASSB
      }
  ) else $error("undefined ALU operation code %0h", iss.op.alu_op);

endmodule

//--- src/ex_branch_res.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch condition, branch and jump targets,
// resolved address and mispredict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_branch_res (
  ex_issue_if.branch         iss,
  output logic               taken,
  output logic               mispredict,
  output ex_isa_pkg::word_t  resolved_addr,
  output ex_isa_pkg::word_t  jump_addr
);

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  logic  is_branch;
  logic  is_jump;
  logic  cond_met;
  word_t rel_target;
  word_t reg_target;

  assign is_branch = iss.valid && (iss.op.kind == KIND_BRANCH);
  assign is_jump   = (iss.op.kind == KIND_JAL) || (iss.op.kind == KIND_JALR);

  always_comb begin
    cond_met = 1'b0;
    case (iss.op.br_cond)
      BR_EQ:   cond_met = iss.op.port_a == iss.op.port_b;
      BR_NE:   cond_met = iss.op.port_a != iss.op.port_b;
      BR_LT:   cond_met = $signed(iss.op.port_a) < $signed(iss.op.port_b);
      BR_GE:   cond_met = $signed(iss.op.port_a) >= $signed(iss.op.port_b);
      BR_LTU:  cond_met = iss.op.port_a < iss.op.port_b;
      BR_GEU:  cond_met = iss.op.port_a >= iss.op.port_b;
      default: cond_met = 1'b0;
    endcase
  end

  // Branches and jal share the pc relative adder
  assign rel_target = iss.op.pc + iss.op.imm;

  // jalr clears the low bit of the register target
  assign reg_target = (iss.op.port_a + iss.op.imm) & ~word_t'(1);

  always_comb begin
    case (iss.op.kind)
      KIND_JAL:  jump_addr = rel_target;
      KIND_JALR: jump_addr = reg_target;
      default:   jump_addr = '0;
    endcase
  end

  assign taken      = is_branch && cond_met;
  assign mispredict = is_branch && (iss.op.prediction ^ cond_met);

  // Not taken and plain ALU ops fall through to pc4
  always_comb begin
    if (is_jump) begin
      resolved_addr = jump_addr;
    end else if (taken) begin
      resolved_addr = rel_target;
    end else begin
      resolved_addr = iss.pc4;
    end
  end

  // Undefined codes would silently resolve as not taken
  a_br_cond_defined: assert property (
    @(posedge iss.CLK) disable iff (!iss.nRST)
    (iss.valid && iss.op.kind == KIND_BRANCH) |->
      iss.op.br_cond inside {BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU}
  ) else $error("undefined branch condition code %0d", iss.op.br_cond);

endmodule

//--- src/ex_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32 word and register index types,
// ALU operation and branch condition codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ex_isa_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  // Shift amount bits taken from port_b
  localparam int unsigned SHAMT_W = 5;

  // Sequential instruction step
  localparam int unsigned PC_STEP = 4;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    ALU_PASSB = 4'd10   // lui passes the immediate through
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } br_cond_t;

endpackage

//--- src/ex_issue_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered operation from issue register to functional units
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

interface ex_issue_if (
  input logic CLK,
  input logic nRST
);

  import ex_pipe_pkg::*;

  logic          valid;
  issue_t        op;
  // Next sequential pc, shared by the branch and jump paths
  ex_isa_pkg::word_t pc4;

  modport driver (
    output valid, op, pc4
  );

  modport alu (
    input CLK, nRST, valid, op
  );

  modport branch (
    input CLK, nRST, valid, op, pc4
  );

endinterface

//--- src/ex_pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation kinds and the issue and commit payloads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ex_pipe_pkg;

  import ex_isa_pkg::*;

  typedef enum logic [1:0] {
    KIND_ALU    = 2'd0,
    KIND_BRANCH = 2'd1,
    KIND_JAL    = 2'd2,
    KIND_JALR   = 2'd3
  } op_kind_t;

  // Decoded operation as held by the issue register
  typedef struct packed {
    op_kind_t kind;
    alu_op_t  alu_op;
    br_cond_t br_cond;
    word_t    port_a;
    word_t    port_b;
    word_t    imm;
    word_t    pc;
    reg_idx_t rd;
    logic     prediction;
  } issue_t;

  // Finished operation as held by the commit latch
  typedef struct packed {
    logic     wen;
    reg_idx_t rd;
    word_t    wdata;
    word_t    pc;
    logic     branch_instr;
    logic     branch_taken;
    logic     mispredict;
    word_t    resolved_addr;
    logic     jump_instr;
    word_t    jump_addr;
  } commit_t;

endpackage

//--- src/ex_stage_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One pipeline slot with valid bit,
// stall hold and flush clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     stall,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // Flush takes priority over stall
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else if (flush) begin
      out_valid <= 1'b0;
      out_data  <= '0;
    end else if (!stall) begin
      out_valid <= in_valid;
      out_data  <= in_data;
    end
  end

  // Upstream must never feed an unknown valid into the slot
  a_valid_known: assert property (
    @(posedge CLK) disable iff (!nRST)
    !$isunknown(out_valid)
  ) else $error("pipeline slot valid is unknown");

endmodule

//--- src/ex_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer execute stage: issue register,
// functional units and commit latch
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_top (
  input  logic                   CLK,
  input  logic                   nRST,
  // Decoded operation
  input  logic                   in_valid,
  input  ex_pipe_pkg::op_kind_t  in_kind,
  input  ex_isa_pkg::alu_op_t    in_alu_op,
  input  ex_isa_pkg::br_cond_t   in_br_cond,
  input  ex_isa_pkg::word_t      port_a,
  input  ex_isa_pkg::word_t      port_b,
  input  ex_isa_pkg::word_t      imm,
  input  ex_isa_pkg::word_t      pc,
  input  ex_isa_pkg::reg_idx_t   rd,
  input  logic                   prediction,
  // Pipeline control
  input  logic                   stall,
  input  logic                   flush,
  // Commit side
  output logic                   commit_valid,
  output logic                   commit_wen,
  output ex_isa_pkg::reg_idx_t   commit_rd,
  output ex_isa_pkg::word_t      commit_wdata,
  output ex_isa_pkg::word_t      commit_pc,
  output logic                   branch_instr,
  output logic                   branch_taken,
  output logic                   mispredict,
  output ex_isa_pkg::word_t      resolved_addr,
  output logic                   jump_instr,
  output ex_isa_pkg::word_t      jump_addr
);

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  issue_t  issue_d;
  commit_t commit_d;
  commit_t commit_q;

  word_t alu_result;
  logic  br_taken;
  logic  br_mispredict;
  word_t br_resolved;
  word_t br_jump_addr;
  logic  is_alu;
  logic  is_jump;
  logic  writes_rd;

  ex_issue_if iss (
    .CLK  (CLK),
    .nRST (nRST)
  );

  // Stage 1: issue register
  always_comb begin
    issue_d.kind       = in_kind;
    issue_d.alu_op     = in_alu_op;
    issue_d.br_cond    = in_br_cond;
    issue_d.port_a     = port_a;
    issue_d.port_b     = port_b;
    issue_d.imm        = imm;
    issue_d.pc         = pc;
    issue_d.rd         = rd;
    issue_d.prediction = prediction;
  end

  ex_stage_reg #(
    .payload_t (issue_t)
  ) issue_reg_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_data   (issue_d),
    .out_valid (iss.valid),
    .out_data  (iss.op)
  );

  assign iss.pc4 = iss.op.pc + PC_STEP;

  // Stage 2: functional units
  ex_alu alu_i (
    .iss    (iss),
    .result (alu_result)
  );

  ex_branch_res branch_res_i (
    .iss           (iss),
    .taken         (br_taken),
    .mispredict    (br_mispredict),
    .resolved_addr (br_resolved),
    .jump_addr     (br_jump_addr)
  );

  assign is_alu  = iss.op.kind == KIND_ALU;
  assign is_jump = (iss.op.kind == KIND_JAL) || (iss.op.kind == KIND_JALR);
  // x0 is hardwired, so writes to it are dropped here
  assign writes_rd = iss.valid && (is_alu || is_jump) && (iss.op.rd != '0);

  always_comb begin
    commit_d               = '0;
    commit_d.wen           = writes_rd;
    commit_d.rd            = iss.op.rd;
    commit_d.pc            = iss.op.pc;
    commit_d.branch_instr  = iss.valid && (iss.op.kind == KIND_BRANCH);
    commit_d.branch_taken  = br_taken;
    commit_d.mispredict    = br_mispredict;
    commit_d.resolved_addr = br_resolved;
    commit_d.jump_instr    = iss.valid && is_jump;
    commit_d.jump_addr     = br_jump_addr;
    // Link value for jumps, nothing for branches
    if (is_alu) begin
      commit_d.wdata = alu_result;
    end else if (is_jump) begin
      commit_d.wdata = iss.pc4;
    end
  end

  // Stage 3: commit latch
  ex_stage_reg #(
    .payload_t (commit_t)
  ) commit_reg_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (iss.valid),
    .in_data   (commit_d),
    .out_valid (commit_valid),
    .out_data  (commit_q)
  );

  assign commit_wen    = commit_q.wen;
  assign commit_rd     = commit_q.rd;
  assign commit_wdata  = commit_q.wdata;
  assign commit_pc     = commit_q.pc;
  assign branch_instr  = commit_q.branch_instr;
  assign branch_taken  = commit_q.branch_taken;
  assign mispredict    = commit_q.mispredict;
  assign resolved_addr = commit_q.resolved_addr;
  assign jump_instr    = commit_q.jump_instr;
  assign jump_addr     = commit_q.jump_addr;

endmodule

//--- verif/ex_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of the execute stage,
// output comparison and error count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_checker (
  input logic                  CLK,
  input logic                  nRST,
  input logic                  in_valid,
  input ex_pipe_pkg::op_kind_t in_kind,
  input ex_isa_pkg::alu_op_t   in_alu_op,
  input ex_isa_pkg::br_cond_t  in_br_cond,
  input ex_isa_pkg::word_t     port_a,
  input ex_isa_pkg::word_t     port_b,
  input ex_isa_pkg::word_t     imm,
  input ex_isa_pkg::word_t     pc,
  input ex_isa_pkg::reg_idx_t  rd,
  input logic                  prediction,
  input logic                  stall,
  input logic                  flush,
  input logic                  commit_valid,
  input logic                  commit_wen,
  input ex_isa_pkg::reg_idx_t  commit_rd,
  input ex_isa_pkg::word_t     commit_wdata,
  input ex_isa_pkg::word_t     commit_pc,
  input logic                  branch_instr,
  input logic                  branch_taken,
  input logic                  mispredict,
  input ex_isa_pkg::word_t     resolved_addr,
  input logic                  jump_instr,
  input ex_isa_pkg::word_t     jump_addr
);

  timeunit 1ns;
  timeprecision 1ps;

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  int      errors = 0;
  logic    iss_v;
  issue_t  iss_m;
  logic    com_v;
  commit_t com_m;
  // Directed results keyed by the pc of their operation
  word_t   exp_by_pc [word_t];

  function automatic commit_t predict(issue_t op, logic v);
    commit_t c;
    word_t   res;
    word_t   pc4;
    logic    tk;
    c   = '0;
    pc4 = op.pc + PC_STEP;
    case (op.alu_op)
      ALU_ADD:  res = op.port_a + op.port_b;
      ALU_SUB:  res = op.port_a - op.port_b;
      ALU_AND:  res = op.port_a & op.port_b;
      ALU_OR:   res = op.port_a | op.port_b;
      ALU_XOR:  res = op.port_a ^ op.port_b;
      ALU_SLL:  res = op.port_a << op.port_b[4:0];
      ALU_SRL:  res = op.port_a >> op.port_b[4:0];
      ALU_SRA:  res = $signed(op.port_a) >>> op.port_b[4:0];
      ALU_SLT:  res = ($signed(op.port_a) < $signed(op.port_b)) ? 32'd1 : 32'd0;
      ALU_SLTU: res = (op.port_a < op.port_b) ? 32'd1 : 32'd0;
      default:  res = op.port_b;
    endcase
    case (op.br_cond)
      BR_EQ:   tk = op.port_a == op.port_b;
      BR_NE:   tk = op.port_a != op.port_b;
      BR_LT:   tk = $signed(op.port_a) < $signed(op.port_b);
      BR_GE:   tk = $signed(op.port_a) >= $signed(op.port_b);
      BR_LTU:  tk = op.port_a < op.port_b;
      default: tk = op.port_a >= op.port_b;
    endcase
    c.rd = op.rd;
    c.pc = op.pc;
    if (v) begin
      case (op.kind)
        KIND_ALU: begin
          c.wen   = op.rd != 0;
          c.wdata = res;
        end
        KIND_BRANCH: begin
          c.branch_instr  = 1'b1;
          c.branch_taken  = tk;
          c.mispredict    = op.prediction ^ tk;
          c.resolved_addr = tk ? op.pc + op.imm : pc4;
        end
        default: begin
          c.jump_instr    = 1'b1;
          c.wen           = op.rd != 0;
          c.wdata         = pc4;
          c.jump_addr     = (op.kind == KIND_JAL) ? op.pc + op.imm
                                                  : (op.port_a + op.imm) & 32'hFFFF_FFFE;
          c.resolved_addr = c.jump_addr;
        end
      endcase
    end
    return c;
  endfunction

  task automatic expect_result(input word_t pc_key, input word_t value);
    exp_by_pc[pc_key] = value;
  endtask

  function automatic int pending_count();
    return exp_by_pc.num();
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Same hold and clear rules as the two pipeline registers
  always @(posedge CLK or negedge nRST) begin
    if (!nRST || flush) begin
      iss_v = 1'b0;
      iss_m = '0;
      com_v = 1'b0;
      com_m = '0;
    end else if (!stall) begin
      com_m = predict(iss_m, iss_v);
      com_v = iss_v;
      iss_v = in_valid;
      iss_m = '{in_kind, in_alu_op, in_br_cond, port_a, port_b, imm, pc, rd, prediction};
    end
  end

  // Outputs are settled half a cycle after the edge
  always @(negedge CLK) begin
    check_word("commit_valid", commit_valid, com_v);
    check_word("commit_wen", commit_wen, com_m.wen);
    check_word("branch_instr", branch_instr, com_m.branch_instr);
    check_word("branch_taken", branch_taken, com_m.branch_taken);
    check_word("mispredict", mispredict, com_m.mispredict);
    check_word("jump_instr", jump_instr, com_m.jump_instr);
    if (!nRST) begin
      check_word("commit_rd", commit_rd, '0);
      check_word("commit_pc", commit_pc, '0);
      check_word("commit_wdata", commit_wdata, '0);
      check_word("resolved_addr", resolved_addr, '0);
      check_word("jump_addr", jump_addr, '0);
    end else if (com_v) begin
      check_word("commit_rd", commit_rd, com_m.rd);
      check_word("commit_pc", commit_pc, com_m.pc);
      if (com_m.wen)
        check_word("commit_wdata", commit_wdata, com_m.wdata);
      if (com_m.branch_instr || com_m.jump_instr)
        check_word("resolved_addr", resolved_addr, com_m.resolved_addr);
      if (com_m.jump_instr)
        check_word("jump_addr", jump_addr, com_m.jump_addr);
      if (exp_by_pc.exists(commit_pc)) begin
        if (branch_instr)
          check_word("directed resolved_addr", resolved_addr, exp_by_pc[commit_pc]);
        else
          check_word("directed commit_wdata", commit_wdata, exp_by_pc[commit_pc]);
        exp_by_pc.delete(commit_pc);
      end
    end
  end

endmodule

//--- verif/ex_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage testbench: clock, reset,
// stimulus table, LFSR and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ex_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ex_isa_pkg::*;
  import ex_pipe_pkg::*;

  typedef struct {
    logic     valid;
    op_kind_t kind;
    alu_op_t  alu_op;
    br_cond_t cond;
    word_t    a;
    word_t    b;
    word_t    imm;
    word_t    pc;
    reg_idx_t rd;
    logic     pred;
    logic     stall;
    logic     flush;
    logic     has_exp;
    word_t    exp;
  } stim_t;

  logic     CLK;
  logic     nRST;
  logic     in_valid, prediction, stall, flush;
  op_kind_t in_kind;
  alu_op_t  in_alu_op;
  br_cond_t in_br_cond;
  word_t    port_a, port_b, imm, pc;
  reg_idx_t rd;
  logic     commit_valid, commit_wen, branch_instr, branch_taken, mispredict, jump_instr;
  reg_idx_t commit_rd;
  word_t    commit_wdata, commit_pc, resolved_addr, jump_addr;

  stim_t    table_q[$];
  word_t    lfsr_state = 32'h592c;
  int       limit_ns = 0;

  ex_top dut_i (.*);
  ex_checker chk_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Galois LFSR, one step per bit taken
  task automatic take_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
  endtask

  task automatic add_op(input op_kind_t k, input alu_op_t op, input br_cond_t c,
                        input word_t a, input word_t b, input word_t i, input word_t p,
                        input reg_idx_t r, input logic pr, input logic he, input word_t e);
    table_q.push_back('{1'b1, k, op, c, a, b, i, p, r, pr, 1'b0, 1'b0, he, e});
  endtask

  task automatic add_rand(input op_kind_t k, input alu_op_t op, input br_cond_t c,
                          input word_t p);
    word_t a;
    word_t b;
    take_bits(32, a);
    take_bits(32, b);
    add_op(k, op, c, a, b, 32'h10, p, 5'd7, 1'b0, 1'b0, '0);
  endtask

  task automatic add_ctrl(input logic s, input logic f);
    table_q.push_back('{1'b0, KIND_ALU, ALU_ADD, BR_EQ, '0, '0, '0, '0, '0, 1'b0, s, f,
                        1'b0, '0});
  endtask

  task automatic drive_entry(input stim_t e);
    in_valid   = e.valid;
    in_kind    = e.kind;
    in_alu_op  = e.alu_op;
    in_br_cond = e.cond;
    port_a     = e.a;
    port_b     = e.b;
    imm        = e.imm;
    pc         = e.pc;
    rd         = e.rd;
    prediction = e.pred;
    stall      = e.stall;
    flush      = e.flush;
  endtask

  task automatic build_table();
    add_op(KIND_ALU, ALU_ADD, BR_EQ, 5, 7, 0, 32'h00, 5'd1, 0, 1, 32'd12);
    add_op(KIND_ALU, ALU_SUB, BR_EQ, 3, 5, 0, 32'h04, 5'd2, 0, 1, 32'hFFFF_FFFE);
    add_op(KIND_ALU, ALU_AND, BR_EQ, 32'hF0F0_F0F0, 32'hFF00_FF00, 0, 32'h08, 5'd3, 0, 1,
           32'hF000_F000);
    add_op(KIND_ALU, ALU_OR, BR_EQ, 32'hF0F0_F0F0, 32'h0F0F_0000, 0, 32'h0C, 5'd4, 0, 1,
           32'hFFFF_F0F0);
    add_op(KIND_ALU, ALU_XOR, BR_EQ, 32'hFFFF_0000, 32'h0FF0_0FF0, 0, 32'h10, 5'd5, 0, 1,
           32'hF00F_0FF0);
    // Only the low five bits of port_b shift
    add_op(KIND_ALU, ALU_SLL, BR_EQ, 1, 32'h24, 0, 32'h14, 5'd6, 0, 1, 32'h10);
    add_op(KIND_ALU, ALU_SRL, BR_EQ, 32'h8000_0000, 4, 0, 32'h18, 5'd7, 0, 1, 32'h0800_0000);
    add_op(KIND_ALU, ALU_SRA, BR_EQ, 32'h8000_0000, 4, 0, 32'h1C, 5'd8, 0, 1, 32'hF800_0000);
    add_op(KIND_ALU, ALU_SLT, BR_EQ, 32'hFFFF_FFFF, 1, 0, 32'h20, 5'd9, 0, 1, 32'd1);
    add_op(KIND_ALU, ALU_SLTU, BR_EQ, 32'hFFFF_FFFF, 1, 0, 32'h24, 5'd10, 0, 1, 32'd0);
    add_op(KIND_ALU, ALU_PASSB, BR_EQ, 0, 32'h1234_5000, 0, 32'h28, 5'd11, 0, 1, 32'h1234_5000);
    add_op(KIND_ALU, ALU_ADD, BR_EQ, 9, 9, 0, 32'h2C, 5'd0, 0, 0, '0);
    // Branches, directed value is the resolved address
    add_op(KIND_BRANCH, ALU_ADD, BR_EQ, 9, 9, 32'h20, 32'h100, 5'd0, 0, 1, 32'h120);
    add_op(KIND_BRANCH, ALU_ADD, BR_NE, 9, 9, 32'h20, 32'h104, 5'd0, 0, 1, 32'h108);
    add_op(KIND_BRANCH, ALU_ADD, BR_LT, 32'hFFFF_FFFF, 1, 32'hFFFF_FFF8, 32'h108, 5'd0, 1, 1,
           32'h100);
    add_op(KIND_BRANCH, ALU_ADD, BR_GE, 32'hFFFF_FFFF, 1, 32'h20, 32'h10C, 5'd0, 1, 1, 32'h110);
    add_op(KIND_BRANCH, ALU_ADD, BR_LTU, 32'hFFFF_FFFF, 1, 32'h20, 32'h110, 5'd0, 1, 1, 32'h114);
    add_op(KIND_BRANCH, ALU_ADD, BR_GEU, 32'hFFFF_FFFF, 1, 32'h40, 32'h114, 5'd0, 1, 1, 32'h154);
    add_op(KIND_JAL, ALU_ADD, BR_EQ, 0, 0, 32'h80, 32'h200, 5'd1, 0, 1, 32'h204);
    add_op(KIND_JALR, ALU_ADD, BR_EQ, 32'h1001, 0, 32'h10, 32'h300, 5'd1, 0, 1, 32'h304);
    add_rand(KIND_ALU, ALU_ADD, BR_EQ, 32'h400);
    add_rand(KIND_ALU, ALU_XOR, BR_EQ, 32'h404);
    add_rand(KIND_ALU, ALU_SRA, BR_EQ, 32'h408);
    add_rand(KIND_ALU, ALU_SLT, BR_EQ, 32'h40C);
    add_rand(KIND_BRANCH, ALU_ADD, BR_LT, 32'h410);
    add_rand(KIND_JALR, ALU_ADD, BR_EQ, 32'h414);
    // Stall holds both slots
    add_ctrl(1'b1, 1'b0);
    add_ctrl(1'b1, 1'b0);
    add_ctrl(1'b0, 1'b0);
    // Two ops in flight, then a flush
    add_op(KIND_ALU, ALU_ADD, BR_EQ, 1, 1, 0, 32'h500, 5'd3, 0, 0, '0);
    add_op(KIND_JAL, ALU_ADD, BR_EQ, 0, 0, 32'h8, 32'h504, 5'd4, 0, 0, '0);
    add_ctrl(1'b1, 1'b1);
    add_ctrl(1'b0, 1'b0);
    add_ctrl(1'b0, 1'b0);
  endtask

  initial begin
    drive_entry('{1'b0, KIND_ALU, ALU_ADD, BR_EQ, '0, '0, '0, '0, '0, 1'b0, 1'b0, 1'b0,
                  1'b0, '0});
    nRST = 1'b0;
    build_table();
    foreach (table_q[i]) begin
      if (table_q[i].has_exp)
        chk_i.expect_result(table_q[i].pc, table_q[i].exp);
    end
    limit_ns = (table_q.size() + 10) * 20;
    repeat (2) @(posedge CLK);
    #2 nRST = 1'b1;
    foreach (table_q[i]) begin
      drive_entry(table_q[i]);
      @(posedge CLK);
      #2;
    end
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    // Let the last comparison at this edge finish first
    #1;
    if (chk_i.pending_count() != 0)
      $display("Error: %0d directed results never reached the commit ports",
               chk_i.pending_count());
    $display("Checks done: %0d errors, %0d directed results missing",
             chk_i.errors, chk_i.pending_count());
    if (chk_i.errors == 0 && chk_i.pending_count() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("Timeout: the stimulus table did not finish within %0d ns", limit_ns);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
